// ==== rob_top.f ====
core_pkg.sv
lane_compact.sv
lane_redirect.sv
data_que.sv
commit_unit.sv
rob_top.sv
tb_rob_top.sv

// ==== Bender.yml ====
package:
  name: rob_top

sources:
  - core_pkg.sv
  - lane_compact.sv
  - lane_redirect.sv
  - data_que.sv
  - commit_unit.sv
  - rob_top.sv
  - target: simulation
    files:
      - tb_rob_top.sv

// ==== tb_rob_top.sv ====
`default_nettype none

module tb_rob_top;

    logic clk = 1'b0;
    logic i_rst_n;
    logic i_enq_vld;
    logic [core_pkg::ENQ_W-1:0] i_enq_req;
    logic [core_pkg::ENQ_W*core_pkg::ENTRY_W-1:0] i_enq_data;
    logic o_can_enq;
    logic [core_pkg::ENQ_W*core_pkg::IDX_W-1:0] o_alloc_idx;
    logic [core_pkg::ENQ_W-1:0] o_alloc_flip;
    logic [core_pkg::CLEAR_W-1:0] i_clear_vld;
    logic [core_pkg::CLEAR_W*core_pkg::IDX_W-1:0] i_clear_idx;
    logic i_commit_stall;
    logic [core_pkg::COMMIT_W-1:0] o_commit_vld;
    logic [core_pkg::COMMIT_W*core_pkg::IDX_W-1:0] o_commit_idx;
    logic [core_pkg::COMMIT_W*core_pkg::ENTRY_W-1:0] o_commit_data;
    logic [core_pkg::INSTRET_W-1:0] o_instret;

    // model queue indexed by allocations since reset
    logic [core_pkg::ENTRY_W-1:0] m_mem [core_pkg::ROB_DEPTH];
    int m_tail = 0;
    int m_head = 0;
    int m_retired = 0;
    logic [15:0] lfsr = 16'd24;
    int errors = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    rob_top u_rob_top (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_enq_vld      (i_enq_vld),
        .i_enq_req      (i_enq_req),
        .i_enq_data     (i_enq_data),
        .o_can_enq      (o_can_enq),
        .o_alloc_idx    (o_alloc_idx),
        .o_alloc_flip   (o_alloc_flip),
        .i_clear_vld    (i_clear_vld),
        .i_clear_idx    (i_clear_idx),
        .i_commit_stall (i_commit_stall),
        .o_commit_vld   (o_commit_vld),
        .o_commit_idx   (o_commit_idx),
        .o_commit_data  (o_commit_data),
        .o_instret      (o_instret)
    );

    always #4 clk = ~clk;

    // galois lfsr with taps 16 14 13 11
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] out;
        out = '0;
        for (int i = 0; i < n; i++) begin
            out[i] = lfsr[0];
            lfsr   = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return out;
    endfunction

    function automatic logic [core_pkg::ENTRY_W-1:0] make_entry();
        logic [63:0] pc;
        logic [63:0] rd;
        logic [63:0] cls;
        pc  = rand_bits(core_pkg::PC_W);
        rd  = rand_bits(core_pkg::RD_W);
        cls = rand_bits(2);
        return {core_pkg::inst_class_e'(cls[1:0]), rd[core_pkg::RD_W-1:0],
                pc[core_pkg::PC_W-1:0]};
    endfunction

    function automatic int count_bits(input logic [3:0] mask);
        int n;
        n = 0;
        for (int i = 0; i < 4; i++) begin
            n += mask[i];
        end
        return n;
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [63:0] exp, input logic [63:0] act);
        $display("ERROR %s: %s expected %h actual %h", name, what, exp, act);
        errors++;
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            pass_cnt++;
            $display("test %s passed", name);
        end else begin
            fail_cnt++;
            $display("test %s failed with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic enqueue(input string name, input logic [3:0] req);
        logic [core_pkg::ENQ_W*core_pkg::ENTRY_W-1:0] data;
        logic exp_can;
        int rank;
        int pos;
        for (int i = 0; i < core_pkg::ENQ_W; i++) begin
            data[i*core_pkg::ENTRY_W +: core_pkg::ENTRY_W] = make_entry();
        end
        exp_can = count_bits(req) <= core_pkg::ROB_DEPTH - (m_tail - m_head);
        @(posedge clk);
        i_enq_vld  <= 1'b1;
        i_enq_req  <= req;
        i_enq_data <= data;
        @(negedge clk);
        if (o_can_enq !== exp_can) report_mismatch(name, "can_enq", exp_can, o_can_enq);
        rank = 0;
        for (int i = 0; i < core_pkg::ENQ_W; i++) begin
            if (req[i]) begin
                pos = m_tail + rank;
                if (o_alloc_idx[i*4 +: 4] !== pos % core_pkg::ROB_DEPTH) begin
                    report_mismatch(name, "alloc_idx", pos % core_pkg::ROB_DEPTH,
                                    o_alloc_idx[i*4 +: 4]);
                end
                if (o_alloc_flip[i] !== (pos / core_pkg::ROB_DEPTH) % 2) begin
                    report_mismatch(name, "alloc_flip", (pos / core_pkg::ROB_DEPTH) % 2,
                                    o_alloc_flip[i]);
                end
                if (exp_can) begin
                    m_mem[pos % core_pkg::ROB_DEPTH] =
                        data[i*core_pkg::ENTRY_W +: core_pkg::ENTRY_W];
                end
                rank++;
            end
        end
        if (exp_can) m_tail += rank;
        @(posedge clk);
        i_enq_vld <= 1'b0;
        i_enq_req <= '0;
    endtask

    // marks n entries from model position first on separate lanes
    task automatic mark_done(input int first, input int n);
        logic [core_pkg::CLEAR_W-1:0] vld;
        logic [core_pkg::CLEAR_W*core_pkg::IDX_W-1:0] idx;
        vld = '0;
        idx = '0;
        for (int c = 0; c < n; c++) begin
            vld[c] = 1'b1;
            idx[c*core_pkg::IDX_W +: core_pkg::IDX_W] = 4'((first + c) % core_pkg::ROB_DEPTH);
        end
        @(posedge clk);
        i_clear_vld <= vld;
        i_clear_idx <= idx;
        @(posedge clk);
        i_clear_vld <= '0;
    endtask

    task automatic no_commit(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (o_commit_vld !== '0) report_mismatch(name, "commit_vld", 0, o_commit_vld);
        end
    endtask

    // first_seen counts falling edges until the first commit shows
    task automatic collect_commits(input string name, input int n, input int limit,
                                   output int first_seen);
        int got;
        int cycles;
        int lanes;
        int exp_lanes;
        logic [3:0] exp_vld;
        first_seen = 0;
        got = 0;
        cycles = 0;
        while (got < n && cycles < limit) begin
            @(negedge clk);
            cycles++;
            lanes = count_bits(o_commit_vld);
            // once the oldest leaves the rest drain four per cycle
            if (lanes == 0 && got == 0) begin
                exp_lanes = 0;
            end else if (n - got < core_pkg::COMMIT_W) begin
                exp_lanes = n - got;
            end else begin
                exp_lanes = core_pkg::COMMIT_W;
            end
            exp_vld = 4'((1 << exp_lanes) - 1);
            if (o_commit_vld !== exp_vld) begin
                report_mismatch(name, "commit_vld", exp_vld, o_commit_vld);
            end
            if (exp_lanes != 0 && first_seen == 0) first_seen = cycles;
            for (int k = 0; k < exp_lanes; k++) begin
                if (o_commit_idx[k*4 +: 4] !== m_head % core_pkg::ROB_DEPTH) begin
                    report_mismatch(name, "commit_idx", m_head % core_pkg::ROB_DEPTH,
                                    o_commit_idx[k*4 +: 4]);
                end
                if (o_commit_data[k*core_pkg::ENTRY_W +: core_pkg::ENTRY_W] !==
                    m_mem[m_head % core_pkg::ROB_DEPTH]) begin
                    report_mismatch(name, "commit_data", m_mem[m_head % core_pkg::ROB_DEPTH],
                                    o_commit_data[k*core_pkg::ENTRY_W +: core_pkg::ENTRY_W]);
                end
                m_head++;
                m_retired++;
                got++;
            end
            if (o_instret !== m_retired) report_mismatch(name, "instret", m_retired, o_instret);
        end
        if (got != n) begin
            $display("%s: saw %0d of %0d commits within %0d cycles", name, got, n, limit);
            errors++;
        end
    endtask

    task automatic reset_state();
        int e;
        e = errors;
        @(negedge clk);
        if (o_can_enq !== 1'b1) report_mismatch("reset_state", "can_enq", 1, o_can_enq);
        if (o_commit_vld !== '0) report_mismatch("reset_state", "commit_vld", 0, o_commit_vld);
        if (o_instret !== '0) report_mismatch("reset_state", "instret", 0, o_instret);
        enqueue("reset_state", 4'b1111);
        end_test("reset_state", e);
    endtask

    task automatic sparse_lanes();
        int e;
        e = errors;
        enqueue("sparse_lanes", 4'b1010);
        enqueue("sparse_lanes", 4'b1111);
        end_test("sparse_lanes", e);
    endtask

    task automatic out_of_order();
        int e;
        int seen;
        e = errors;
        mark_done(m_head + 1, 3);
        no_commit("out_of_order", 4);
        mark_done(m_head, 1);
        collect_commits("out_of_order", 4, 10, seen);
        // strobe edge plus the retire edge
        if (seen != 2) report_mismatch("out_of_order", "edges to commit", 2, seen);
        end_test("out_of_order", e);
    endtask

    task automatic full_queue();
        int e;
        int seen;
        e = errors;
        enqueue("full_queue", 4'b1111);
        enqueue("full_queue", 4'b1111);
        enqueue("full_queue", 4'b0011);
        enqueue("full_queue", 4'b0001);
        enqueue("full_queue", 4'b1111);
        mark_done(m_head, 1);
        collect_commits("full_queue", 1, 10, seen);
        enqueue("full_queue", 4'b0011);
        enqueue("full_queue", 4'b0100);
        end_test("full_queue", e);
    endtask

    task automatic stall_drain();
        int e;
        int seen;
        e = errors;
        @(posedge clk);
        i_commit_stall <= 1'b1;
        for (int g = 0; g < 4; g++) begin
            mark_done(m_head + 4 * g, 4);
        end
        no_commit("stall_drain", 4);
        @(posedge clk);
        i_commit_stall <= 1'b0;
        collect_commits("stall_drain", 16, 20, seen);
        end_test("stall_drain", e);
    endtask

    // the third request crosses entry 15 so only its last lane flips back
    task automatic index_wrap();
        int e;
        e = errors;
        enqueue("index_wrap", 4'b1111);
        enqueue("index_wrap", 4'b1111);
        enqueue("index_wrap", 4'b1111);
        end_test("index_wrap", e);
    endtask

    initial begin
        i_rst_n        = 1'b0;
        i_enq_vld      = 1'b0;
        i_enq_req      = '0;
        i_enq_data     = '0;
        i_clear_vld    = '0;
        i_clear_idx    = '0;
        i_commit_stall = 1'b0;
        repeat (2) @(posedge clk);
        i_rst_n <= 1'b1;
        reset_state();
        sparse_lanes();
        out_of_order();
        full_queue();
        stall_drain();
        index_wrap();
        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (2000) @(posedge clk);
        $display("simulation ran past its cycle limit");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rob_top.sv ====
`default_nettype none

module rob_top (
    input  wire                                              clk,
    input  wire                                              i_rst_n,

    // enqueue from rename
    input  wire                                              i_enq_vld,
    input  wire  [core_pkg::ENQ_W-1:0]                       i_enq_req,
    input  wire  [core_pkg::ENQ_W*core_pkg::ENTRY_W-1:0]     i_enq_data,
    output logic                                             o_can_enq,
    output logic [core_pkg::ENQ_W*core_pkg::IDX_W-1:0]       o_alloc_idx,
    output logic [core_pkg::ENQ_W-1:0]                       o_alloc_flip,

    // completion from execution
    input  wire  [core_pkg::CLEAR_W-1:0]                     i_clear_vld,
    input  wire  [core_pkg::CLEAR_W*core_pkg::IDX_W-1:0]     i_clear_idx,

    input  wire                                              i_commit_stall,

    // commit bus
    output logic [core_pkg::COMMIT_W-1:0]                    o_commit_vld,
    output logic [core_pkg::COMMIT_W*core_pkg::IDX_W-1:0]    o_commit_idx,
    output logic [core_pkg::COMMIT_W*core_pkg::ENTRY_W-1:0]  o_commit_data,
    output logic [core_pkg::INSTRET_W-1:0]                   o_instret
);

    logic [core_pkg::COMMIT_W-1:0]                   will_clear_vld;
    logic [core_pkg::COMMIT_W*core_pkg::IDX_W-1:0]   will_clear_idx;
    logic [core_pkg::COMMIT_W*core_pkg::ENTRY_W-1:0] will_clear_data;

    data_que u_data_que (
        .clk               (clk),
        .i_rst_n           (i_rst_n),
        .i_commit_stall    (i_commit_stall),
        .i_enq_vld         (i_enq_vld),
        .i_enq_req         (i_enq_req),
        .i_enq_data        (i_enq_data),
        .o_can_enq         (o_can_enq),
        .o_alloc_idx       (o_alloc_idx),
        .o_alloc_flip      (o_alloc_flip),
        .i_clear_vld       (i_clear_vld),
        .i_clear_idx       (i_clear_idx),
        .o_will_clear_vld  (will_clear_vld),
        .o_will_clear_idx  (will_clear_idx),
        .o_will_clear_data (will_clear_data)
    );

    // one register stage between retire and the bus
    commit_unit u_commit_unit (
        .clk               (clk),
        .i_rst_n           (i_rst_n),
        .i_will_clear_vld  (will_clear_vld),
        .i_will_clear_idx  (will_clear_idx),
        .i_will_clear_data (will_clear_data),
        .o_commit_vld      (o_commit_vld),
        .o_commit_idx      (o_commit_idx),
        .o_commit_data     (o_commit_data),
        .o_instret         (o_instret)
    );

endmodule

`default_nettype wire

// ==== commit_unit.sv ====
`default_nettype none

module commit_unit (
    input  wire                                              clk,
    input  wire                                              i_rst_n,
    input  wire  [core_pkg::COMMIT_W-1:0]                    i_will_clear_vld,
    input  wire  [core_pkg::COMMIT_W*core_pkg::IDX_W-1:0]    i_will_clear_idx,
    input  wire  [core_pkg::COMMIT_W*core_pkg::ENTRY_W-1:0]  i_will_clear_data,
    output logic [core_pkg::COMMIT_W-1:0]                    o_commit_vld,
    output logic [core_pkg::COMMIT_W*core_pkg::IDX_W-1:0]    o_commit_idx,
    output logic [core_pkg::COMMIT_W*core_pkg::ENTRY_W-1:0]  o_commit_data,
    output logic [core_pkg::INSTRET_W-1:0]                   o_instret
);

    logic [core_pkg::INSTRET_W-1:0] retire_num;
    logic [core_pkg::PC_W-1:0]      ret_pc  [core_pkg::COMMIT_W];
    logic [core_pkg::RD_W-1:0]      ret_rd  [core_pkg::COMMIT_W];
    core_pkg::inst_class_e          ret_cls [core_pkg::COMMIT_W];

    assign retire_num = {{(core_pkg::INSTRET_W-core_pkg::CNT_W){1'b0}},
                         core_pkg::lane_count(i_will_clear_vld)};

    // split the retiring entries into their fields
    always_comb begin
        for (int k = 0; k < core_pkg::COMMIT_W; k++) begin
            ret_pc[k]  = i_will_clear_data[k*core_pkg::ENTRY_W + core_pkg::ENT_PC_LSB
                                           +: core_pkg::PC_W];
            ret_rd[k]  = i_will_clear_data[k*core_pkg::ENTRY_W + core_pkg::ENT_RD_LSB
                                           +: core_pkg::RD_W];
            ret_cls[k] = core_pkg::inst_class_e'(
                i_will_clear_data[k*core_pkg::ENTRY_W + core_pkg::ENT_CLS_LSB
                                  +: core_pkg::CLS_W]);
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_commit_vld <= '0;
            o_instret    <= '0;
        end else begin
            o_commit_vld <= i_will_clear_vld;
            o_instret    <= o_instret + retire_num;
        end
    end

    // payload only loads on lanes that retire
    always_ff @(posedge clk) begin
        for (int k = 0; k < core_pkg::COMMIT_W; k++) begin
            if (i_will_clear_vld[k]) begin
                o_commit_idx[k*core_pkg::IDX_W +: core_pkg::IDX_W] <=
                    i_will_clear_idx[k*core_pkg::IDX_W +: core_pkg::IDX_W];
                o_commit_data[k*core_pkg::ENTRY_W + core_pkg::ENT_PC_LSB +: core_pkg::PC_W] <=
                    ret_pc[k];
                o_commit_data[k*core_pkg::ENTRY_W + core_pkg::ENT_RD_LSB +: core_pkg::RD_W] <=
                    ret_rd[k];
                o_commit_data[k*core_pkg::ENTRY_W + core_pkg::ENT_CLS_LSB +: core_pkg::CLS_W] <=
                    ret_cls[k];
            end
        end
    end

endmodule

`default_nettype wire

// ==== data_que.sv ====
`default_nettype none

module data_que (
    input  wire                                              clk,
    input  wire                                              i_rst_n,
    input  wire                                              i_commit_stall,
    input  wire                                              i_enq_vld,
    input  wire  [core_pkg::ENQ_W-1:0]                       i_enq_req,
    input  wire  [core_pkg::ENQ_W*core_pkg::ENTRY_W-1:0]     i_enq_data,
    output logic                                             o_can_enq,
    output logic [core_pkg::ENQ_W*core_pkg::IDX_W-1:0]       o_alloc_idx,
    output logic [core_pkg::ENQ_W-1:0]                       o_alloc_flip,
    input  wire  [core_pkg::CLEAR_W-1:0]                     i_clear_vld,
    input  wire  [core_pkg::CLEAR_W*core_pkg::IDX_W-1:0]     i_clear_idx,
    output logic [core_pkg::COMMIT_W-1:0]                    o_will_clear_vld,
    output logic [core_pkg::COMMIT_W*core_pkg::IDX_W-1:0]    o_will_clear_idx,
    output logic [core_pkg::COMMIT_W*core_pkg::ENTRY_W-1:0]  o_will_clear_data
);

    logic [core_pkg::ENTRY_W-1:0]   mem [core_pkg::ROB_DEPTH];
    logic [core_pkg::ROB_DEPTH-1:0] vld_bits;
    logic [core_pkg::ROB_DEPTH-1:0] cmp_bits;

    // one pointer per lane, lane k sits k entries past the base
    logic [core_pkg::IDX_W-1:0]  tail_ptr [core_pkg::ENQ_W];
    logic [core_pkg::ENQ_W-1:0]  tail_flip;
    logic [core_pkg::IDX_W-1:0]  head_ptr [core_pkg::COMMIT_W];
    logic [core_pkg::IDX_W:0]    tail_nxt [core_pkg::ENQ_W];
    logic [core_pkg::IDX_W:0]    head_nxt [core_pkg::COMMIT_W];
    logic [core_pkg::CNT_W-1:0]  count;

    logic [core_pkg::CNT_W-1:0] free_num;
    logic [core_pkg::CNT_W-1:0] req_num;
    logic [core_pkg::CNT_W-1:0] enq_num;
    logic [core_pkg::CNT_W-1:0] clear_num;
    logic                       enq_fire;

    logic [core_pkg::ENQ_W-1:0]                   slot_vld;
    logic [core_pkg::ENQ_W*core_pkg::ENTRY_W-1:0] slot_data;
    logic [core_pkg::ENQ_W*core_pkg::IDX_W-1:0]   tail_flat;
    logic [core_pkg::COMMIT_W-1:0]                can_clear;

    // pointer plus step, top bit set when it passed the last entry
    function automatic logic [core_pkg::IDX_W:0] ptr_add(
        input logic [core_pkg::IDX_W-1:0] ptr,
        input logic [core_pkg::CNT_W-1:0] step
    );
        logic [core_pkg::CNT_W-1:0] sum;
        logic [core_pkg::CNT_W-1:0] wrapped;
        sum     = {1'b0, ptr} + step;
        wrapped = sum - core_pkg::ROB_DEPTH_C;
        if (sum >= core_pkg::ROB_DEPTH_C) begin
            return {1'b1, wrapped[core_pkg::IDX_W-1:0]};
        end
        return {1'b0, sum[core_pkg::IDX_W-1:0]};
    endfunction

    lane_compact u_lane_compact (
        .i_req  (i_enq_req),
        .i_data (i_enq_data),
        .o_vld  (slot_vld),
        .o_data (slot_data)
    );

    // hand each requester the pointer of its slot
    lane_redirect #(
        .WIDTH (core_pkg::IDX_W)
    ) u_redirect_idx (
        .i_req      (i_enq_req),
        .i_slot_val (tail_flat),
        .o_lane_val (o_alloc_idx)
    );

    lane_redirect #(
        .WIDTH (1)
    ) u_redirect_flip (
        .i_req      (i_enq_req),
        .i_slot_val (tail_flip),
        .o_lane_val (o_alloc_flip)
    );

    // all or nothing
    assign free_num  = core_pkg::ROB_DEPTH_C - count;
    assign req_num   = core_pkg::lane_count(i_enq_req);
    assign o_can_enq = req_num <= free_num;
    assign enq_fire  = i_enq_vld & o_can_enq;
    assign enq_num   = enq_fire ? req_num : '0;
    assign clear_num = core_pkg::lane_count(can_clear);

    // retire chain, stops at the first entry not yet done
    always_comb begin
        logic ok;
        ok = ~i_commit_stall;
        for (int k = 0; k < core_pkg::COMMIT_W; k++) begin
            ok           = ok & vld_bits[head_ptr[k]] & cmp_bits[head_ptr[k]];
            can_clear[k] = ok;
        end
    end

    always_comb begin
        for (int j = 0; j < core_pkg::ENQ_W; j++) begin
            tail_nxt[j] = ptr_add(tail_ptr[j], enq_num);
            tail_flat[j*core_pkg::IDX_W +: core_pkg::IDX_W] = tail_ptr[j];
        end
        for (int k = 0; k < core_pkg::COMMIT_W; k++) begin
            head_nxt[k] = ptr_add(head_ptr[k], clear_num);
            o_will_clear_idx[k*core_pkg::IDX_W +: core_pkg::IDX_W] = head_ptr[k];
            o_will_clear_data[k*core_pkg::ENTRY_W +: core_pkg::ENTRY_W] = mem[head_ptr[k]];
        end
    end

    assign o_will_clear_vld = can_clear;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vld_bits  <= '0;
            cmp_bits  <= '0;
            count     <= '0;
            tail_flip <= '0;
            for (int j = 0; j < core_pkg::ENQ_W; j++) begin
                tail_ptr[j] <= j[core_pkg::IDX_W-1:0];
            end
            for (int k = 0; k < core_pkg::COMMIT_W; k++) begin
                head_ptr[k] <= k[core_pkg::IDX_W-1:0];
            end
        end else begin
            count <= count + enq_num - clear_num;

            // completion marks from execution
            for (int c = 0; c < core_pkg::CLEAR_W; c++) begin
                if (i_clear_vld[c]) begin
                    cmp_bits[i_clear_idx[c*core_pkg::IDX_W +: core_pkg::IDX_W]] <= 1'b1;
                end
            end

            // retire frees the slot for reuse
            for (int k = 0; k < core_pkg::COMMIT_W; k++) begin
                if (can_clear[k]) begin
                    vld_bits[head_ptr[k]] <= 1'b0;
                    cmp_bits[head_ptr[k]] <= 1'b0;
                end
                head_ptr[k] <= head_nxt[k][core_pkg::IDX_W-1:0];
            end

            // allocated slots never overlap live ones
            if (enq_fire) begin
                for (int j = 0; j < core_pkg::ENQ_W; j++) begin
                    if (slot_vld[j]) begin
                        vld_bits[tail_ptr[j]] <= 1'b1;
                    end
                    tail_ptr[j]  <= tail_nxt[j][core_pkg::IDX_W-1:0];
                    tail_flip[j] <= tail_flip[j] ^ tail_nxt[j][core_pkg::IDX_W];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            for (int j = 0; j < core_pkg::ENQ_W; j++) begin
                if (slot_vld[j]) begin
                    mem[tail_ptr[j]] <= slot_data[j*core_pkg::ENTRY_W +: core_pkg::ENTRY_W];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== lane_redirect.sv ====
`default_nettype none

module lane_redirect #(
    parameter int WIDTH = core_pkg::IDX_W
) (
    input  wire  [core_pkg::ENQ_W-1:0]       i_req,
    input  wire  [core_pkg::ENQ_W*WIDTH-1:0] i_slot_val,
    output logic [core_pkg::ENQ_W*WIDTH-1:0] o_lane_val
);

    logic [core_pkg::CNT_W-1:0] rank [core_pkg::ENQ_W];

    // a lane's slot is the number of requesters below it
    always_comb begin
        for (int i = 0; i < core_pkg::ENQ_W; i++) begin
            rank[i] = core_pkg::lane_rank(i_req, i);
        end
    end

    // idle lanes still read some slot, value is don't care
    always_comb begin
        for (int i = 0; i < core_pkg::ENQ_W; i++) begin
            o_lane_val[i*WIDTH +: WIDTH] = i_slot_val[rank[i]*WIDTH +: WIDTH];
        end
    end

endmodule

`default_nettype wire

// ==== lane_compact.sv ====
`default_nettype none

module lane_compact (
    input  wire  [core_pkg::ENQ_W-1:0]                  i_req,
    input  wire  [core_pkg::ENQ_W*core_pkg::ENTRY_W-1:0] i_data,
    output logic [core_pkg::ENQ_W-1:0]                  o_vld,
    output logic [core_pkg::ENQ_W*core_pkg::ENTRY_W-1:0] o_data
);

    logic [core_pkg::CNT_W-1:0] rank [core_pkg::ENQ_W];
    logic [core_pkg::CNT_W-1:0] req_num;

    always_comb begin
        for (int i = 0; i < core_pkg::ENQ_W; i++) begin
            rank[i] = core_pkg::lane_rank(i_req, i);
        end
    end

    assign req_num = core_pkg::lane_count(i_req);

    // scatter each requesting lane into its slot
    always_comb begin
        o_data = '0;
        for (int i = 0; i < core_pkg::ENQ_W; i++) begin
            if (i_req[i]) begin
                o_data[rank[i]*core_pkg::ENTRY_W +: core_pkg::ENTRY_W] =
                    i_data[i*core_pkg::ENTRY_W +: core_pkg::ENTRY_W];
            end
        end
    end

    // thermometer of requester count
    always_comb begin
        for (int s = 0; s < core_pkg::ENQ_W; s++) begin
            o_vld[s] = s < req_num;
        end
    end

endmodule

`default_nettype wire

// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    // queue geometry
    localparam int ROB_DEPTH = 16;
    localparam int IDX_W     = 4;
    localparam int CNT_W     = 5;

    // lanes per cycle
    localparam int ENQ_W    = 4;
    localparam int CLEAR_W  = 4;
    localparam int COMMIT_W = 4;

    // entry layout, pc at the bottom and class on top
    localparam int PC_W    = 32;
    localparam int RD_W    = 5;
    localparam int CLS_W   = 2;
    localparam int ENTRY_W = CLS_W + RD_W + PC_W;

    localparam int ENT_PC_LSB  = 0;
    localparam int ENT_RD_LSB  = ENT_PC_LSB + PC_W;
    localparam int ENT_CLS_LSB = ENT_RD_LSB + RD_W;

    localparam int INSTRET_W = 32;

    // depth at counter width
    localparam logic [CNT_W-1:0] ROB_DEPTH_C = CNT_W'(ROB_DEPTH);

    typedef enum logic [CLS_W-1:0] {
        cls_alu    = 2'd0,
        cls_load   = 2'd1,
        cls_store  = 2'd2,
        cls_branch = 2'd3
    } inst_class_e;

    // set bits in a lane mask
    function automatic logic [CNT_W-1:0] lane_count(input logic [ENQ_W-1:0] mask);
        logic [CNT_W-1:0] sum;
        sum = '0;
        for (int i = 0; i < ENQ_W; i++) begin
            sum = sum + {{(CNT_W-1){1'b0}}, mask[i]};
        end
        return sum;
    endfunction

    // requesters below a lane, i.e. the slot that lane lands in
    function automatic logic [CNT_W-1:0] lane_rank(input logic [ENQ_W-1:0] mask, input int lane);
        logic [ENQ_W-1:0] below;
        below = '0;
        for (int i = 0; i < ENQ_W; i++) begin
            if (i < lane) begin
                below[i] = mask[i];
            end
        end
        return lane_count(below);
    endfunction

endpackage

`default_nettype wire
